/* files.f */
+incdir+testbench
rtl/bist_pkg.sv
rtl/bank_ram.sv
rtl/bank_queue.sv
rtl/pattern_source.sv
rtl/pattern_checker.sv
rtl/bank_sequencer.sv
rtl/interleave_bist_top.sv
testbench/tb_interleave_bist.sv

/* rtl/bank_queue.sv */
`timescale 1ns/1ps

module bank_queue (
  input  logic                   CLK,
  input  logic                   RESET,
  input  logic                   write,
  input  logic                   pop,
  input  bist_pkg::word_t        wdata,
  output bist_pkg::bank_status_t status
);

  bist_pkg::bank_addr_t head;   // next free slot
  bist_pkg::bank_addr_t tail;   // oldest word
  bist_pkg::bank_addr_t head_plus1;
  bist_pkg::word_t      rdata;

  assign head_plus1 = head + bist_pkg::bank_addr_t'(1);

  // ####################
  // ring pointers
  // ####################

  always_ff @(posedge CLK) begin
    if (RESET) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (write) begin
        head <= head_plus1;
      end
      if (pop) begin
        tail <= tail + bist_pkg::bank_addr_t'(1);
      end
    end
  end

  bank_ram i_bank_ram (
    .CLK   (CLK),
    .write (write),
    .waddr (head),
    .wdata (wdata),
    .raddr (tail),
    .rdata (rdata)
  );

  // one slot kept open so full and empty differ
  assign status.full  = (head_plus1 == tail);
  assign status.empty = (head == tail);
  assign status.rdata = rdata;

endmodule

/* rtl/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram (
  input  logic                 CLK,
  input  logic                 write,
  input  bist_pkg::bank_addr_t waddr,
  input  bist_pkg::word_t      wdata,
  input  bist_pkg::bank_addr_t raddr,
  output bist_pkg::word_t      rdata
);

  bist_pkg::word_t mem [bist_pkg::BANK_DEPTH];

  // output register stages like the block RAM's pipelined read port
  bist_pkg::word_t rd_pipe [bist_pkg::BANK_READ_LATENCY];

  always_ff @(posedge CLK) begin
    if (write) begin
      mem[waddr] <= wdata;
    end
  end

  always_ff @(posedge CLK) begin
    rd_pipe[0] <= mem[raddr];
    for (int s = 1; s < bist_pkg::BANK_READ_LATENCY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign rdata = rd_pipe[bist_pkg::BANK_READ_LATENCY-1];

endmodule

/* rtl/bank_sequencer.sv */
`timescale 1ns/1ps

module bank_sequencer (
  input  logic                                            CLK,
  input  logic                                            RESET,
  input  logic                                            run,
  input  logic                                            stall_check,
  input  bist_pkg::bank_status_t [bist_pkg::NUM_BANKS-1:0] bank_status,
  input  logic                                            match,
  output bist_pkg::bank_cmd_t                             cmd,
  output logic                                            advance,
  output logic                                            accept,
  output bist_pkg::bist_state_e                           state
);

  localparam bist_pkg::bank_sel_t LAST_BANK =
    bist_pkg::bank_sel_t'(bist_pkg::NUM_BANKS - 1);

  bist_pkg::bist_state_e  state_next;
  bist_pkg::bank_sel_t    ptr;        // bank visited this cycle
  bist_pkg::bank_sel_t    ptr_next;
  bist_pkg::bank_status_t cur;
  logic                   ptr_step;

  assign cur      = bank_status[ptr];
  assign ptr_next = (ptr == LAST_BANK) ? '0 : ptr + bist_pkg::bank_sel_t'(1);

  // pointer freezes on pause and once in ERROR
  assign ptr_step = run && (state != bist_pkg::ERROR);

  // ####################
  // visit decision
  // ####################

  always_comb begin
    cmd        = '0;
    cmd.bank   = ptr;
    accept     = 1'b0;
    state_next = state;

    if (run) begin
      case (state)
        bist_pkg::INIT: begin
          // prime every bank with one word
          cmd.write = 1'b1;
          if (ptr == LAST_BANK) begin
            state_next = bist_pkg::OK;
          end
        end

        bist_pkg::OK: begin
          if (cur.full) begin
            state_next = bist_pkg::ERROR;  // the read side never caught up
          end else begin
            cmd.write = 1'b1;
            if (!stall_check && !cur.empty) begin
              if (match) begin
                cmd.pop = 1'b1;
                accept  = 1'b1;
              end else begin
                state_next = bist_pkg::ERROR;
              end
            end
          end
        end

        default: begin
          // ERROR drives no strobes
        end
      endcase
    end
  end

  assign advance = cmd.write;   // one new word per write

  // ####################
  // state and pointer
  // ####################

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state <= bist_pkg::INIT;
      ptr   <= '0;
    end else begin
      state <= state_next;
      if (ptr_step) begin
        ptr <= ptr_next;
      end
    end
  end

endmodule

/* rtl/bist_pkg.sv */
package bist_pkg;

  // ####################
  // sizes
  // ####################

  localparam int NUM_BANKS         = 5;   // interleave factor
  localparam int BANK_ADDR_WIDTH   = 4;
  localparam int BANK_DEPTH        = 2 ** BANK_ADDR_WIDTH;
  localparam int DATA_WIDTH        = 21;
  localparam int BANK_READ_LATENCY = 4;   // must stay below NUM_BANKS
  localparam int BANK_SEL_WIDTH    = 3;
  localparam int COUNT_WIDTH       = 24;

  // ####################
  // types
  // ####################

  typedef logic [DATA_WIDTH-1:0]      word_t;
  typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;  // ring pointer
  typedef logic [BANK_SEL_WIDTH-1:0]  bank_sel_t;

  typedef enum logic [1:0] {
    INIT  = 2'd0,
    OK    = 2'd1,
    ERROR = 2'd2   // sticky until reset
  } bist_state_e;

  // per-cycle strobes from the sequencer
  typedef struct packed {
    logic      write;
    logic      pop;
    bank_sel_t bank;
  } bank_cmd_t;

  // one per bank queue
  typedef struct packed {
    logic  full;
    logic  empty;
    word_t rdata;  // oldest word, after the RAM output stages
  } bank_status_t;

  typedef struct packed {
    bist_state_e            state;
    logic [COUNT_WIDTH-1:0] checked_count;
  } bist_status_t;

endpackage

/* rtl/interleave_bist_top.sv */
`timescale 1ns/1ps

module interleave_bist_top (
  input  logic                   CLK,
  input  logic                   RESET,
  input  logic                   run,
  input  logic                   stall_check,
  input  logic                   corrupt,
  output bist_pkg::bist_status_t status
);

  bist_pkg::bank_cmd_t                              cmd;
  bist_pkg::bank_status_t [bist_pkg::NUM_BANKS-1:0] bank_status;
  bist_pkg::word_t                                  wdata;
  bist_pkg::bist_state_e                            state;
  logic [bist_pkg::COUNT_WIDTH-1:0]                 checked_count;
  logic                                             advance;
  logic                                             accept;
  logic                                             match;
  logic [bist_pkg::NUM_BANKS-1:0]                   bank_write;
  logic [bist_pkg::NUM_BANKS-1:0]                   bank_pop;

  // ####################
  // control
  // ####################

  bank_sequencer i_bank_sequencer (
    .CLK         (CLK),
    .RESET       (RESET),
    .run         (run),
    .stall_check (stall_check),
    .bank_status (bank_status),
    .match       (match),
    .cmd         (cmd),
    .advance     (advance),
    .accept      (accept),
    .state       (state)
  );

  pattern_source i_pattern_source (
    .CLK     (CLK),
    .RESET   (RESET),
    .advance (advance),
    .corrupt (corrupt),
    .wdata   (wdata)
  );

  pattern_checker i_pattern_checker (
    .CLK           (CLK),
    .RESET         (RESET),
    .bank          (cmd.bank),
    .bank_status   (bank_status),
    .accept        (accept),
    .match         (match),
    .checked_count (checked_count)
  );

  // ####################
  // bank queues
  // ####################

  for (genvar i = 0; i < bist_pkg::NUM_BANKS; i++) begin : g_bank
    // only the visited bank sees a strobe
    assign bank_write[i] = cmd.write && (cmd.bank == bist_pkg::bank_sel_t'(i));
    assign bank_pop[i]   = cmd.pop && (cmd.bank == bist_pkg::bank_sel_t'(i));

    bank_queue i_bank_queue (
      .CLK    (CLK),
      .RESET  (RESET),
      .write  (bank_write[i]),
      .pop    (bank_pop[i]),
      .wdata  (wdata),        // shared write bus
      .status (bank_status[i])
    );
  end

  // both fields come straight from registers
  assign status = '{state: state, checked_count: checked_count};

endmodule

/* rtl/pattern_checker.sv */
`timescale 1ns/1ps

module pattern_checker (
  input  logic                                            CLK,
  input  logic                                            RESET,
  input  bist_pkg::bank_sel_t                             bank,
  input  bist_pkg::bank_status_t [bist_pkg::NUM_BANKS-1:0] bank_status,
  input  logic                                            accept,
  output logic                                            match,
  output logic [bist_pkg::COUNT_WIDTH-1:0]                checked_count
);

  bist_pkg::word_t expected;
  bist_pkg::word_t rdata_sel;

  // ####################
  // compare
  // ####################

  // words come back in write order, bank by bank
  assign rdata_sel = bank_status[bank].rdata;
  assign match     = (rdata_sel == expected);

  // ####################
  // counters
  // ####################

  always_ff @(posedge CLK) begin
    if (RESET) begin
      expected      <= '0;
      checked_count <= '0;
    end else if (accept) begin
      expected      <= expected + bist_pkg::word_t'(1);
      checked_count <= checked_count + bist_pkg::COUNT_WIDTH'(1);
    end
  end

endmodule

/* rtl/pattern_source.sv */
`timescale 1ns/1ps

module pattern_source (
  input  logic            CLK,
  input  logic            RESET,
  input  logic            advance,
  input  logic            corrupt,
  output bist_pkg::word_t wdata
);

  bist_pkg::word_t count;
  logic            pending;   // corruption waiting for a write
  logic            flip;

  // a pulse in the write cycle itself takes effect at once
  assign flip  = pending | corrupt;
  assign wdata = count ^ bist_pkg::word_t'(flip);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      count   <= '0;
      pending <= 1'b0;
    end else begin
      if (advance) begin
        count   <= count + bist_pkg::word_t'(1);
        pending <= 1'b0;   // one-shot
      end else if (corrupt) begin
        pending <= 1'b1;
      end
    end
  end

endmodule

/* testbench/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// ####################
// random source
// ####################

logic [15:0] lfsr_state;

// galois form of x^16 + x^14 + x^13 + x^11 + 1
function automatic logic next_random_bit();
  logic out_bit;
  out_bit    = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out_bit) begin
    lfsr_state = lfsr_state ^ 16'hB400;
  end
  return out_bit;
endfunction

// ####################
// bookkeeping
// ####################

int error_count;
int tests_done;
int tests_failed;
int test_start_errors;

task automatic flag_value(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
  $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  error_count++;
endtask

task automatic flag_event(input string what);
  $display("ERROR: %s at %0t", what, $time);
  error_count++;
endtask

task automatic begin_test();
  test_start_errors = error_count;
endtask

task automatic end_test(input string name);
  int errs;
  errs = error_count - test_start_errors;
  tests_done++;
  if (errs == 0) begin
    $display("test %0d, %s: ok", tests_done, name);
  end else begin
    tests_failed++;
    $display("test %0d, %s: %0d errors", tests_done, name, errs);
  end
endtask

`endif

/* testbench/tb_interleave_bist.sv */
`timescale 1ns/1ps

module tb_interleave_bist;

  localparam int CLK_PERIOD        = 40;
  localparam int RESET_CYCLES      = 4;
  localparam logic [15:0] LFSR_SEED = 16'd95;
  localparam int CLEAN_CYCLES      = 60;
  localparam int RANDOM_CYCLES     = 200;
  localparam int ERROR_HOLD_CYCLES = 20;
  localparam int OK_LIMIT          = bist_pkg::NUM_BANKS + 2;
  localparam int FULL_LIMIT        = bist_pkg::BANK_DEPTH * bist_pkg::NUM_BANKS + 2;
  localparam int TOTAL_CYCLES      = 3 * RESET_CYCLES + 2 + 2 * (OK_LIMIT + CLEAN_CYCLES + 1)
                                     + RANDOM_CYCLES + (OK_LIMIT + ERROR_HOLD_CYCLES + 2)
                                     + FULL_LIMIT + 1;
  localparam int WATCHDOG_MARGIN   = 50;

  localparam bist_pkg::bank_sel_t LAST_BANK =
    bist_pkg::bank_sel_t'(bist_pkg::NUM_BANKS - 1);

  logic                   CLK;
  logic                   RESET;
  logic                   run;
  logic                   stall_check;
  logic                   corrupt;
  bist_pkg::bist_status_t status;

  `include "tb_util.svh"

  interleave_bist_top i_interleave_bist_top (
    .CLK         (CLK),
    .RESET       (RESET),
    .run         (run),
    .stall_check (stall_check),
    .corrupt     (corrupt),
    .status      (status)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // ####################
  // reference model
  // ####################

  bist_pkg::bist_state_e m_state;
  bist_pkg::bank_sel_t   m_ptr;
  int                    m_occ [bist_pkg::NUM_BANKS];   // words held per bank
  int                    m_writes;
  int                    m_checks;
  int                    m_bad_idx;   // write index of the corrupted word
  logic                  m_pending;

  always @(posedge CLK) begin : ref_model
    int   occ_now;
    logic wr;
    wr      = 1'b0;
    occ_now = 0;
    if (RESET) begin
      m_state   <= bist_pkg::INIT;
      m_ptr     <= '0;
      m_writes  <= 0;
      m_checks  <= 0;
      m_bad_idx <= -1;
      m_pending <= 1'b0;
      for (int b = 0; b < bist_pkg::NUM_BANKS; b++) begin
        m_occ[b] <= 0;
      end
    end else begin
      if (run && m_state != bist_pkg::ERROR) begin
        occ_now = m_occ[m_ptr];
        if (m_state == bist_pkg::INIT) begin
          wr = 1'b1;
          if (m_ptr == LAST_BANK) begin
            m_state <= bist_pkg::OK;
          end
        end else if (occ_now == bist_pkg::BANK_DEPTH - 1) begin
          m_state <= bist_pkg::ERROR;   // full guard
        end else begin
          wr = 1'b1;
          if (!stall_check && occ_now > 0) begin
            // pops come back in global write order
            if (m_checks == m_bad_idx) begin
              m_state <= bist_pkg::ERROR;
            end else begin
              m_checks <= m_checks + 1;
              occ_now--;
            end
          end
        end
        m_ptr <= (m_ptr == LAST_BANK) ? '0 : m_ptr + 1'b1;
      end
      if (wr) begin
        m_occ[m_ptr] <= occ_now + 1;
        m_writes     <= m_writes + 1;
        if (m_pending || corrupt) begin
          m_bad_idx <= m_writes;
        end
        m_pending <= 1'b0;
      end else if (corrupt) begin
        m_pending <= 1'b1;   // waits for the next write
      end
    end
  end

  // ####################
  // assertions
  // ####################

  a_reset_state: assert property (@(posedge CLK)
    $fell(RESET) |-> status.state == bist_pkg::INIT)
    else flag_value("status.state", 32'($sampled(status.state)), 32'(bist_pkg::INIT));

  a_reset_count: assert property (@(posedge CLK)
    $fell(RESET) |-> status.checked_count == '0)
    else flag_value("status.checked_count", 32'($sampled(status.checked_count)), 32'h0);

  a_count_model: assert property (@(posedge CLK) disable iff (RESET)
    status.checked_count == bist_pkg::COUNT_WIDTH'(m_checks))
    else flag_value("status.checked_count", 32'($sampled(status.checked_count)),
                    32'($sampled(m_checks)));

  a_state_model: assert property (@(posedge CLK) disable iff (RESET)
    status.state == m_state)
    else flag_value("status.state", 32'($sampled(status.state)), 32'($sampled(m_state)));

  // no accept on a pause, a stalled read side or after a failure
  a_count_holds: assert property (@(posedge CLK) disable iff (RESET)
    (!run || stall_check || status.state == bist_pkg::ERROR)
      |=> $stable(status.checked_count))
    else flag_event("checked_count moved on a cycle without a check");

  a_error_sticky: assert property (@(posedge CLK) disable iff (RESET)
    status.state == bist_pkg::ERROR |=> status.state == bist_pkg::ERROR)
    else flag_value("status.state", 32'($sampled(status.state)), 32'(bist_pkg::ERROR));

  // ####################
  // stimulus
  // ####################

  task automatic apply_reset();
    RESET       <= 1'b1;
    run         <= 1'b0;
    stall_check <= 1'b0;
    corrupt     <= 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    RESET <= 1'b0;
  endtask

  task automatic wait_for_state(input bist_pkg::bist_state_e target, input int limit);
    int waited;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
    end while (status.state != target && waited < limit);
    if (status.state != target) begin
      flag_event($sformatf("state %s not reached within %0d cycles", target.name(), limit));
    end
  endtask

  task automatic clean_run();
    run <= 1'b1;
    wait_for_state(bist_pkg::OK, OK_LIMIT);
    repeat (CLEAN_CYCLES) @(posedge CLK);
    run <= 1'b0;
    @(posedge CLK);
  endtask

  initial begin
    RESET             = 1'b1;
    run               = 1'b0;
    stall_check       = 1'b0;
    corrupt           = 1'b0;
    lfsr_state        = LFSR_SEED;
    error_count       = 0;
    tests_done        = 0;
    tests_failed      = 0;
    test_start_errors = 0;

    begin_test();
    apply_reset();
    repeat (2) @(posedge CLK);
    end_test("reset values");

    begin_test();
    clean_run();
    end_test("run held high");

    begin_test();
    repeat (RANDOM_CYCLES) begin
      run <= next_random_bit() | next_random_bit();   // about 3 in 4 cycles run
      @(posedge CLK);
    end
    run <= 1'b0;
    end_test("random run gating");

    begin_test();
    run     <= 1'b1;
    corrupt <= 1'b1;
    @(posedge CLK);
    corrupt <= 1'b0;
    wait_for_state(bist_pkg::ERROR, OK_LIMIT);
    repeat (ERROR_HOLD_CYCLES) @(posedge CLK);
    run <= 1'b0;
    end_test("corrupted word");

    begin_test();
    apply_reset();
    stall_check <= 1'b1;
    run         <= 1'b1;
    wait_for_state(bist_pkg::ERROR, FULL_LIMIT);
    run         <= 1'b0;
    stall_check <= 1'b0;
    end_test("full guard");

    begin_test();
    apply_reset();
    clean_run();
    end_test("clean run after reset");

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_done, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_CYCLES + WATCHDOG_MARGIN));
    flag_event("watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule
